//--- project.f
verilog/txnPkg.sv
verilog/dependencyCheck.sv
verilog/threadTable.sv
verilog/completionControl.sv
verilog/txnTracker.sv
verif/txnTracker_properties.sv
verif/txnTrackerTb.sv

//--- verif/txnTrackerTb.sv
`timescale 1ns/1ps

module txnTrackerTb;

	localparam int directedCycles = 32;	// fresh 2, limit 9, ordering 5, full 11, completion 5
	localparam int randomCycles   = 200;
	localparam int cycleLimit     = 2 + directedCycles + randomCycles + 40;	// reset plus margin

	logic                          sysClk;
	logic                          sysReset;
	logic                          reqValid;
	logic [txnPkg::idWidth-1:0]    reqId;
	logic [txnPkg::slaveWidth-1:0] reqSlave;
	logic                          respValid;
	logic [txnPkg::idWidth-1:0]    respId;
	logic                          respLast;
	logic                          grantValid;
	logic [txnPkg::idWidth-1:0]    grantId;
	logic [txnPkg::slaveWidth-1:0] grantSlave;
	logic                          rejectValid;
	logic                          doneValid;
	logic [txnPkg::idWidth-1:0]    doneId;
	logic [txnPkg::slaveWidth-1:0] doneSlave;
	logic                          respError;

	// reference thread table
	logic [txnPkg::idWidth-1:0]    mId    [txnPkg::numThreads];
	logic [txnPkg::slaveWidth-1:0] mSlave [txnPkg::numThreads];
	int                            mCnt   [txnPkg::numThreads];
	bit                            mActive[txnPkg::numThreads];

	int          errorCount = 0;
	int          checkCount = 0;
	int          cycleCount = 0;
	logic [31:0] lcgState;

	txnTracker i_dut (.*);

	always #5 sysClk = ~sysClk;	// 10 ns period

	// watchdog on total run length
	always @(posedge sysClk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: the run went past %0d cycles without finishing", cycleLimit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ======================================================================
	// helpers and compare tasks
	// ======================================================================

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int findThread(input logic [txnPkg::idWidth-1:0] id);
		int idx;
		idx = -1;
		for (int i = 0; i < txnPkg::numThreads; i++)
			if (mActive[i] && mId[i] == id)
				idx = i;
		return idx;	// -1 when nothing open
	endfunction

	function automatic int lowestFree();
		int idx;
		idx = -1;
		for (int i = 0; i < txnPkg::numThreads; i++)
			if (!mActive[i] && idx < 0)
				idx = i;
		return idx;
	endfunction

	task automatic checkStrobe(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic checkId(input string name, input logic [txnPkg::idWidth-1:0] expected,
			input logic [txnPkg::idWidth-1:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkSlave(input string name, input logic [txnPkg::slaveWidth-1:0] expected,
			input logic [txnPkg::slaveWidth-1:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// ======================================================================
	// one cycle: predict, drive on the falling edge, check at the next one
	// ======================================================================

	task automatic stepCycle(input logic rv, input logic [txnPkg::idWidth-1:0] rid,
			input logic [txnPkg::slaveWidth-1:0] rs, input logic pv,
			input logic [txnPkg::idWidth-1:0] pid, input logic pl);
		int                            reqIdx;
		int                            respIdx;
		int                            freeIdx;
		logic                          accept;
		logic                          expGrant;
		logic                          expDone;
		logic [txnPkg::slaveWidth-1:0] expDoneSlave;
		reqIdx  = findThread(rid);	// lookups see the table before the edge
		respIdx = findThread(pid);
		freeIdx = lowestFree();
		if (reqIdx >= 0)
			accept = (mSlave[reqIdx] == rs) && (mCnt[reqIdx] < txnPkg::openTransMax);
		else
			accept = (freeIdx >= 0);
		expGrant     = rv && accept;
		expDone      = pv && pl && (respIdx >= 0);
		expDoneSlave = (respIdx >= 0) ? mSlave[respIdx] : '0;
		reqValid  = rv;
		reqId     = rid;
		reqSlave  = rs;
		respValid = pv;
		respId    = pid;
		respLast  = pl;
		// table update, inc then dec so a shared thread nets to zero
		if (expGrant && reqIdx < 0)
		begin
			mId[freeIdx]     = rid;
			mSlave[freeIdx]  = rs;
			mCnt[freeIdx]    = 1;
			mActive[freeIdx] = 1'b1;
		end
		else if (expGrant)
			mCnt[reqIdx]++;
		if (expDone)
		begin
			mCnt[respIdx]--;
			if (mCnt[respIdx] == 0)
				mActive[respIdx] = 1'b0;
		end
		@(negedge sysClk);
		checkStrobe("grantValid", expGrant, grantValid);
		checkStrobe("rejectValid", rv && !accept, rejectValid);
		checkStrobe("doneValid", expDone, doneValid);
		checkStrobe("respError", pv && (respIdx < 0), respError);
		if (expGrant)
		begin
			checkId("grantId", rid, grantId);
			checkSlave("grantSlave", rs, grantSlave);
		end
		if (expDone)
		begin
			checkId("doneId", pid, doneId);
			checkSlave("doneSlave", expDoneSlave, doneSlave);
		end
	endtask

	task automatic request(input logic [txnPkg::idWidth-1:0] id,
			input logic [txnPkg::slaveWidth-1:0] slave);
		stepCycle(1'b1, id, slave, 1'b0, '0, 1'b0);
	endtask

	task automatic response(input logic [txnPkg::idWidth-1:0] id, input logic last);
		stepCycle(1'b0, '0, '0, 1'b1, id, last);
	endtask

	// ======================================================================
	// directed tests
	// ======================================================================

	task automatic testFreshId();
		request(4'h1, 2'd2);
		response(4'h1, 1'b1);	// leave the table empty
	endtask

	task automatic testOpenLimit();
		repeat (txnPkg::openTransMax + 1)
			request(4'h2, 2'd1);	// last one hits the limit
		response(4'h2, 1'b1);
		request(4'h2, 2'd1);	// one slot reopened
		repeat (txnPkg::openTransMax)
			response(4'h2, 1'b1);
	endtask

	task automatic testOrdering();
		request(4'h3, 2'd0);
		request(4'h3, 2'd1);	// other slave while open
		response(4'h3, 1'b1);
		request(4'h3, 2'd1);	// drained, so allowed now
		response(4'h3, 1'b1);
	endtask

	task automatic testTableFull();
		for (int i = 0; i < txnPkg::numThreads; i++)
			request(4'(4 + i), 2'(i));
		request(4'h8, 2'd0);	// no free thread
		request(4'h5, 2'd1);	// open ID on its own slave
		response(4'h4, 1'b1);
		response(4'h5, 1'b1);
		response(4'h5, 1'b1);
		response(4'h6, 1'b1);
		response(4'h7, 1'b1);
	endtask

	task automatic testCompletion();
		request(4'h9, 2'd3);
		response(4'h9, 1'b0);	// non-last beat, silent
		response(4'h9, 1'b1);
		response(4'h9, 1'b1);	// thread already freed
		response(4'ha, 1'b0);	// never opened
	endtask

	task automatic testRandomMix();
		logic [19:0] r;
		for (int n = 0; n < randomCycles; n++)
		begin
			lcgState = lcgNext(lcgState);
			r = lcgState[31:12];	// upper bits of the LCG
			// narrow ID and slave ranges to force collisions and a full table
			stepCycle(r[0], {1'b0, r[3:1]}, {1'b0, r[4]}, r[5], {1'b0, r[8:6]}, r[9] | r[10]);
		end
	endtask

	initial
	begin
		sysClk    = 1'b0;
		sysReset  = 1'b0;
		reqValid  = 1'b0;
		reqId     = '0;
		reqSlave  = '0;
		respValid = 1'b0;
		respId    = '0;
		respLast  = 1'b0;
		lcgState  = 32'ha3da;
		for (int i = 0; i < txnPkg::numThreads; i++)
			mActive[i] = 1'b0;
		repeat (2) @(negedge sysClk);
		sysReset = 1'b1;
		checkStrobe("grantValid", 1'b0, grantValid);
		checkStrobe("rejectValid", 1'b0, rejectValid);
		checkStrobe("doneValid", 1'b0, doneValid);
		checkStrobe("respError", 1'b0, respError);
		testFreshId();
		testOpenLimit();
		testOrdering();
		testTableFull();
		testCompletion();
		testRandomMix();
		$display("%0d errors in %0d checks", errorCount, checkCount);
		if (errorCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- verif/txnTracker_properties.sv
`timescale 1ns/1ps

// strobe sanity on the tracker boundary
module txnTracker_properties (
	input logic sysClk,
	input logic sysReset,
	input logic reqValid,
	input logic respValid,
	input logic respLast,
	input logic grantValid,
	input logic rejectValid,
	input logic doneValid,
	input logic respError
);

	// ======================================================================
	// one result per request, one per response
	// ======================================================================

	grantRejectExclusive: assert property (@(posedge sysClk) disable iff (!sysReset)
		!(grantValid && rejectValid)) else $error("grant and reject in one cycle");
	doneErrorExclusive: assert property (@(posedge sysClk) disable iff (!sysReset)
		!(doneValid && respError)) else $error("done and response error in one cycle");

	// every output strobe traces back to its input strobe one cycle earlier
	grantFromReq: assert property (@(posedge sysClk) disable iff (!sysReset)
		grantValid |-> $past(reqValid)) else $error("grant without a request");
	rejectFromReq: assert property (@(posedge sysClk) disable iff (!sysReset)
		rejectValid |-> $past(reqValid)) else $error("reject without a request");
	doneFromLast: assert property (@(posedge sysClk) disable iff (!sysReset)
		doneValid |-> $past(respValid && respLast)) else $error("done without a last beat");
	errorFromResp: assert property (@(posedge sysClk) disable iff (!sysReset)
		respError |-> $past(respValid)) else $error("response error without a beat");

endmodule

bind txnTracker txnTracker_properties i_properties (.*);

//--- verilog/completionControl.sv
`timescale 1ns/1ps

// consumer side of the tracker
// closes one transaction per last response beat
module completionControl (
	input  logic                          sysClk,
	input  logic                          sysReset,

	// response beat from the slave side
	input  logic                          respValid,
	input  logic [txnPkg::idWidth-1:0]    respId,
	input  logic                          respLast,

	// thread table answer for respId
	input  logic                          dataValid,
	input  logic [txnPkg::slaveWidth-1:0] dataSlaveID,

	output logic [txnPkg::idWidth-1:0]    currDataTransID,
	output logic                          openTransDec,
	output logic                          doneValid,
	output logic [txnPkg::idWidth-1:0]    doneId,
	output logic [txnPkg::slaveWidth-1:0] doneSlave,
	output logic                          respError
);

	logic unknownId;	// beat for an ID with nothing open

	assign currDataTransID = respId;	// response ID is the data key

	// ======================================================================
	// decrement, nothing or error
	// ======================================================================

	assign openTransDec = respValid && respLast && dataValid;
	assign unknownId    = respValid && !dataValid;	// any beat, last or not

	always_ff @(posedge sysClk or negedge sysReset)
	begin
		if (!sysReset)
		begin
			doneValid <= 1'b0;
			respError <= 1'b0;
		end
		else
		begin
			doneValid <= openTransDec;
			respError <= unknownId;
		end
	end

	// slave sampled now, the thread may be freed at this edge
	always_ff @(posedge sysClk)
	begin
		if (openTransDec)
		begin
			doneId    <= respId;
			doneSlave <= dataSlaveID;
		end
	end

endmodule

//--- verilog/dependencyCheck.sv
`timescale 1ns/1ps

// producer side of the tracker
// checks each request against the thread table and reports grant or reject
module dependencyCheck (
	input  logic                          sysClk,
	input  logic                          sysReset,

	// request strobe from the master
	input  logic                          reqValid,
	input  logic [txnPkg::idWidth-1:0]    reqId,
	input  logic [txnPkg::slaveWidth-1:0] reqSlave,

	// thread table answer for reqId, same cycle
	input  logic                          threadValid,	// an active thread holds reqId
	input  logic                          threadAvail,	// a free slot exists
	input  logic [txnPkg::countWidth-1:0] threadCount,	// open count of that thread
	input  logic [txnPkg::slaveWidth-1:0] threadSlaveID,	// slave of that thread

	output logic                          openTransInc,	// one cycle per accepted request
	output logic                          grantValid,
	output logic                          rejectValid,
	output logic [txnPkg::idWidth-1:0]    grantId,
	output logic [txnPkg::slaveWidth-1:0] grantSlave
);

	logic sameSlave;	// open thread already points at reqSlave
	logic belowMax;		// room for one more on that thread
	logic accept;

	// ======================================================================
	// acceptance rule
	// ======================================================================

	assign sameSlave = (threadSlaveID == reqSlave);
	assign belowMax  = (threadCount < txnPkg::countWidth'(txnPkg::openTransMax));

	// new ID needs a free slot, known ID must keep its slave and stay under the limit
	assign accept = threadValid ? (sameSlave && belowMax) : threadAvail;

	assign openTransInc = reqValid && accept;	// table sees it at the next edge

	// ======================================================================
	// result strobes, one cycle after the request
	// ======================================================================

	always_ff @(posedge sysClk or negedge sysReset)
	begin
		if (!sysReset)
		begin
			grantValid  <= 1'b0;
			rejectValid <= 1'b0;
		end
		else
		begin
			grantValid  <= openTransInc;
			rejectValid <= reqValid && !accept;
		end
	end

	// granted fields, only meaningful alongside grantValid
	always_ff @(posedge sysClk)
	begin
		if (openTransInc)
		begin
			grantId    <= reqId;
			grantSlave <= reqSlave;
		end
	end

endmodule

//--- verilog/threadTable.sv
`timescale 1ns/1ps

// thread table between producer and consumer
// one slot per open ID with its slave and open count
module threadTable (
	input  logic                          sysClk,
	input  logic                          sysReset,

	// request side lookup
	input  logic [txnPkg::idWidth-1:0]    currTransID,
	input  logic [txnPkg::slaveWidth-1:0] currTransSlaveID,
	input  logic                          openTransInc,	// open one more on currTransID

	// response side lookup
	input  logic [txnPkg::idWidth-1:0]    currDataTransID,
	input  logic                          openTransDec,	// close one on currDataTransID

	output logic                          threadAvail,
	output logic                          threadValid,
	output logic [txnPkg::countWidth-1:0] threadCount,
	output logic [txnPkg::slaveWidth-1:0] threadSlaveID,
	output logic                          dataValid,
	output logic [txnPkg::slaveWidth-1:0] dataSlaveID
);

	// per-thread storage
	logic [txnPkg::idWidth-1:0]     threadId    [txnPkg::numThreads];
	logic [txnPkg::slaveWidth-1:0]  threadSlave [txnPkg::numThreads];
	logic [txnPkg::countWidth-1:0]  threadCnt   [txnPkg::numThreads];
	logic [txnPkg::numThreads-1:0]  activeMask;	// slot holds an open ID

	logic [txnPkg::numThreads-1:0]  matchThread;	// one-hot, request key
	logic [txnPkg::numThreads-1:0]  matchData;	// one-hot, response key
	logic [txnPkg::threadWidth-1:0] matchIdx;
	logic [txnPkg::threadWidth-1:0] dataIdx;
	logic [txnPkg::threadWidth-1:0] freeIdx;	// lowest inactive slot

	logic [txnPkg::numThreads-1:0]  allocThread;	// new ID lands here
	logic [txnPkg::numThreads-1:0]  incThread;
	logic [txnPkg::numThreads-1:0]  decThread;

	// one-hot match to slot index, at most one bit is set
	function automatic logic [txnPkg::threadWidth-1:0] hotToIndex(
		input logic [txnPkg::numThreads-1:0] oneHot
	);
		logic [txnPkg::threadWidth-1:0] idx;
		idx = '0;
		for (int k = 0; k < txnPkg::numThreads; k++)
		begin
			if (oneHot[k])
				idx = idx | txnPkg::threadWidth'(k);
		end
		return idx;
	endfunction

	// scan downward so the lowest free slot wins
	function automatic logic [txnPkg::threadWidth-1:0] findFree(
		input logic [txnPkg::numThreads-1:0] mask
	);
		logic [txnPkg::threadWidth-1:0] idx;
		idx = '0;
		for (int k = txnPkg::numThreads - 1; k >= 0; k--)
		begin
			if (!mask[k])
				idx = txnPkg::threadWidth'(k);
		end
		return idx;
	endfunction

	// ======================================================================
	// lookups, combinational
	// ======================================================================

	always_comb
	begin
		for (int i = 0; i < txnPkg::numThreads; i++)
		begin
			matchThread[i] = activeMask[i] && (threadId[i] == currTransID);
			matchData[i]   = activeMask[i] && (threadId[i] == currDataTransID);	// freed slots never answer
		end
	end

	assign matchIdx = hotToIndex(matchThread);
	assign dataIdx  = hotToIndex(matchData);
	assign freeIdx  = findFree(activeMask);

	assign threadAvail   = ~&activeMask;
	assign threadValid   = |matchThread;
	assign threadCount   = threadCnt[matchIdx];
	assign threadSlaveID = threadSlave[matchIdx];
	assign dataValid     = |matchData;
	assign dataSlaveID   = threadSlave[dataIdx];

	// per-slot update requests
	always_comb
	begin
		for (int i = 0; i < txnPkg::numThreads; i++)
		begin
			allocThread[i] = openTransInc && !threadValid && threadAvail && (freeIdx == i);
			incThread[i]   = openTransInc && matchThread[i];
			decThread[i]   = openTransDec && matchData[i];
		end
	end

	// ======================================================================
	// count and active mask
	// ======================================================================

	always_ff @(posedge sysClk or negedge sysReset)
	begin
		if (!sysReset)
		begin
			activeMask <= '0;	// every slot free
			for (int i = 0; i < txnPkg::numThreads; i++)
				threadCnt[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < txnPkg::numThreads; i++)
			begin
				if (allocThread[i])
				begin
					activeMask[i] <= 1'b1;
					threadCnt[i]  <= txnPkg::countWidth'(1);
				end
				else if (incThread[i] && !decThread[i])
					threadCnt[i] <= threadCnt[i] + 1'b1;
				else if (decThread[i] && !incThread[i])
				begin
					threadCnt[i] <= threadCnt[i] - 1'b1;
					if (threadCnt[i] == txnPkg::countWidth'(1))
						activeMask[i] <= 1'b0;	// last one out frees the slot
				end
				// inc and dec on one slot cancel out
			end
		end
	end

	// ID and slave written once per allocation
	always_ff @(posedge sysClk)
	begin
		for (int i = 0; i < txnPkg::numThreads; i++)
		begin
			if (allocThread[i])
			begin
				threadId[i]    <= currTransID;
				threadSlave[i] <= currTransSlaveID;
			end
		end
	end

endmodule

//--- verilog/txnPkg.sv
// ==========================================================================
// shared widths and limits for the outstanding-transaction tracker
// ==========================================================================

package txnPkg;

	// transaction and slave fields
	localparam int idWidth = 4;		// bits in a transaction ID
	localparam int slaveWidth = 2;		// bits in a slave number

	// thread table geometry
	localparam int numThreads = 4;		// thread slots
	localparam int threadWidth = 2;		// encodes a slot index

	// per-thread open count
	localparam int openTransMax = 3;	// most open transactions per ID
	localparam int countWidth = 2;		// must hold openTransMax

	// a full count has to fit in the count field
	localparam int countCeiling = (1 << countWidth) - 1;

endpackage

//--- verilog/txnTracker.sv
`timescale 1ns/1ps

// outstanding-transaction tracker for one master port
// producer, thread table and consumer wired together
module txnTracker (
	input  logic                          sysClk,
	input  logic                          sysReset,

	// request side
	input  logic                          reqValid,
	input  logic [txnPkg::idWidth-1:0]    reqId,
	input  logic [txnPkg::slaveWidth-1:0] reqSlave,

	// response side
	input  logic                          respValid,
	input  logic [txnPkg::idWidth-1:0]    respId,
	input  logic                          respLast,

	output logic                          grantValid,
	output logic [txnPkg::idWidth-1:0]    grantId,
	output logic [txnPkg::slaveWidth-1:0] grantSlave,
	output logic                          rejectValid,
	output logic                          doneValid,
	output logic [txnPkg::idWidth-1:0]    doneId,
	output logic [txnPkg::slaveWidth-1:0] doneSlave,
	output logic                          respError
);

	// ======================================================================
	// producer to table
	// ======================================================================

	logic                          threadValid;
	logic                          threadAvail;
	logic [txnPkg::countWidth-1:0] threadCount;
	logic [txnPkg::slaveWidth-1:0] threadSlaveID;
	logic                          openTransInc;

	// ======================================================================
	// consumer to table
	// ======================================================================

	logic [txnPkg::idWidth-1:0]    currDataTransID;
	logic                          openTransDec;
	logic                          dataValid;
	logic [txnPkg::slaveWidth-1:0] dataSlaveID;

	dependencyCheck i_dependencyCheck (
		.sysClk        (sysClk),
		.sysReset      (sysReset),
		.reqValid      (reqValid),
		.reqId         (reqId),
		.reqSlave      (reqSlave),
		.threadValid   (threadValid),
		.threadAvail   (threadAvail),
		.threadCount   (threadCount),
		.threadSlaveID (threadSlaveID),
		.openTransInc  (openTransInc),
		.grantValid    (grantValid),
		.rejectValid   (rejectValid),
		.grantId       (grantId),
		.grantSlave    (grantSlave)
	);

	// request fields go straight in as lookup keys
	threadTable i_threadTable (
		.sysClk           (sysClk),
		.sysReset         (sysReset),
		.currTransID      (reqId),
		.currTransSlaveID (reqSlave),
		.openTransInc     (openTransInc),
		.currDataTransID  (currDataTransID),
		.openTransDec     (openTransDec),
		.threadAvail      (threadAvail),
		.threadValid      (threadValid),
		.threadCount      (threadCount),
		.threadSlaveID    (threadSlaveID),
		.dataValid        (dataValid),
		.dataSlaveID      (dataSlaveID)
	);

	completionControl i_completionControl (
		.sysClk          (sysClk),
		.sysReset        (sysReset),
		.respValid       (respValid),
		.respId          (respId),
		.respLast        (respLast),
		.dataValid       (dataValid),
		.dataSlaveID     (dataSlaveID),
		.currDataTransID (currDataTransID),
		.openTransDec    (openTransDec),
		.doneValid       (doneValid),
		.doneId          (doneId),
		.doneSlave       (doneSlave),
		.respError       (respError)
	);

endmodule
